/* src/tama_defs.svh */
// tama core shared constants
// rom geometry, download slot ids, image write width and cpu clock divider
`ifndef TAMA_DEFS_SVH
`define TAMA_DEFS_SVH

////////////////////
// program rom
// 16 bit words, cpu only sees the low 12 bits
`define TAMA_ROM_DEPTH 8192
`define TAMA_ROM_ADDR_W 13
`define TAMA_ROM_DATA_W 12

////////////////////
// download bus
// byte address as delivered by the host
`define TAMA_LOAD_ADDR_W 21
// image memory write address
`define TAMA_IMAGE_ADDR_W 17

// data slot ids
`define TAMA_SLOT_ROM 0
`define TAMA_SLOT_BACKGROUND 10
`define TAMA_SLOT_SPRITESHEET 11

// divider reload, one cpu tick every count + 1 cycles
`define TAMA_CLOCK_DIV_COUNT 400

`endif

/* src/tama_load_pkg.sv */
// download side types
// raw host load write and its decoded, slot classified form
`include "tama_defs.svh"

package tama_load_pkg;

  ////////////////////
  // raw load write, one word per strobe
  typedef struct packed {
    logic                         wr;
    logic [`TAMA_LOAD_ADDR_W-1:0] addr;
    logic [15:0]                  data;
    logic [15:0]                  slot_id;
  } load_write_t;

  // where a download word ends up
  typedef enum logic [1:0] {
    target_none,
    target_rom,
    target_background,
    target_spritesheet
  } download_target_e;

  ////////////////////
  // registered load write after slot decode
  // both data orders carried so consumers just pick one
  typedef struct packed {
    logic                         valid;
    download_target_e             target;
    logic [`TAMA_LOAD_ADDR_W-1:0] addr;
    logic [15:0]                  data_raw;
    logic [15:0]                  data_swapped;
  } decoded_write_t;

endpackage

/* src/tama_mem_pkg.sv */
// memory side types
// image write port toward video memory, rom word, splitter states
`include "tama_defs.svh"

package tama_mem_pkg;

  ////////////////////
  // image write port
  // one strobe per target memory, shared addr and data
  typedef struct packed {
    logic                          background_we;
    logic                          spritesheet_we;
    logic [`TAMA_IMAGE_ADDR_W-1:0] addr;
    logic [15:0]                   data;
  } image_write_t;

  // program rom storage word
  // upper nibble is stored but never read by the cpu
  typedef logic [15:0] rom_word_t;

  ////////////////////
  // spritesheet splitter states
  // high byte goes out one cycle after the full word
  typedef enum logic {
    split_idle,
    split_high_byte
  } split_state_e;

endpackage

// typical spritesheet sequence, per load word:
//   cycle 0  word at byte address
//   cycle 1  high byte at byte address + 1

/* src/download_decode.sv */
// download decode
// registers each host load write, sorts it by data slot id
// and prepares the byte-swapped word for rom and background targets
`timescale 1ns/1ps
`include "tama_defs.svh"

module download_decode
  import tama_load_pkg::*;
(
  input  logic           clk_32_768,
  input  logic           rst,
  input  load_write_t    load,
  output decoded_write_t dec
);

  // slot ids sized to the bus field
  localparam logic [15:0] SLOT_ROM         = 16'(`TAMA_SLOT_ROM);
  localparam logic [15:0] SLOT_BACKGROUND  = 16'(`TAMA_SLOT_BACKGROUND);
  localparam logic [15:0] SLOT_SPRITESHEET = 16'(`TAMA_SLOT_SPRITESHEET);

  download_target_e target_next;
  logic             valid_q;
  download_target_e target_q;
  logic [`TAMA_LOAD_ADDR_W-1:0] addr_q;
  logic [15:0]      data_raw_q;
  logic [15:0]      data_swapped_q;

  ////////////////////
  // slot classify
  always_comb begin
    if (load.slot_id == SLOT_ROM) begin
      target_next = target_rom;
    end else if (load.slot_id == SLOT_BACKGROUND) begin
      target_next = target_background;
    end else if (load.slot_id == SLOT_SPRITESHEET) begin
      target_next = target_spritesheet;
    end else begin
      // unknown slot, still flagged valid downstream
      target_next = target_none;
    end
  end

  // strobe only
  always_ff @(posedge clk_32_768) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= load.wr;
    end
  end

  // payload, captured on every strobe
  always_ff @(posedge clk_32_768) begin
    if (load.wr) begin
      target_q       <= target_next;
      addr_q         <= load.addr;
      data_raw_q     <= load.data;
      // host sends big endian words
      data_swapped_q <= {load.data[7:0], load.data[15:8]};
    end
  end

  assign dec = '{valid: valid_q, target: target_q, addr: addr_q,
                 data_raw: data_raw_q, data_swapped: data_swapped_q};

endmodule

/* src/image_write_split.sv */
// image write splitter
// background words pass straight to the background write port,
// spritesheet words go out as the full word then its high byte alone
`timescale 1ns/1ps
`include "tama_defs.svh"

module image_write_split
  import tama_load_pkg::*;
  import tama_mem_pkg::*;
(
  input  logic           clk_32_768,
  input  logic           rst,
  input  decoded_write_t dec,
  output image_write_t   image_wr
);

  split_state_e state;
  logic         bg_we_q;
  logic         sp_we_q;
  logic [`TAMA_IMAGE_ADDR_W-1:0] addr_q;
  logic [15:0]  data_q;
  logic         bg_hit;
  logic         sp_hit;

  assign bg_hit = dec.valid && (dec.target == target_background);
  assign sp_hit = dec.valid && (dec.target == target_spritesheet);

  ////////////////////
  // control, strobes and state
  always_ff @(posedge clk_32_768) begin
    if (rst) begin
      state   <= split_idle;
      bg_we_q <= 1'b0;
      sp_we_q <= 1'b0;
    end else begin
      bg_we_q <= 1'b0;
      sp_we_q <= 1'b0;
      case (state)
        split_idle: begin
          bg_we_q <= bg_hit;
          sp_we_q <= sp_hit;
          if (sp_hit) begin
            state <= split_high_byte;
          end
        end
        split_high_byte: begin
          // second spritesheet write, always taken
          sp_we_q <= 1'b1;
          state   <= split_idle;
        end
        default: state <= split_idle;
      endcase
    end
  end

  // addr and data, no reset
  always_ff @(posedge clk_32_768) begin
    if (state == split_high_byte) begin
      // next byte address, high byte still sits in data_q
      addr_q <= addr_q + 1'b1;
      data_q <= {8'h00, data_q[15:8]};
    end else if (sp_hit) begin
      // spritesheet is byte addressed, word kept unswapped
      addr_q <= dec.addr[`TAMA_IMAGE_ADDR_W-1:0];
      data_q <= dec.data_raw;
    end else if (bg_hit) begin
      // background is word addressed
      addr_q <= dec.addr[`TAMA_IMAGE_ADDR_W:1];
      data_q <= dec.data_swapped;
    end
  end

  assign image_wr = '{background_we: bg_we_q, spritesheet_we: sp_we_q,
                      addr: addr_q, data: data_q};

  // load writes must be two cycles apart, else the high byte slot collides
  a_no_write_during_high_byte: assert property (
    @(posedge clk_32_768) disable iff (rst)
    (state == split_high_byte) |-> !(bg_hit || sp_hit)
  );

endmodule

/* src/program_rom.sv */
// program rom
// 8k x 16 words loaded from slot 0 downloads,
// cpu reads the low 12 bits with one cycle latency
`timescale 1ns/1ps
`include "tama_defs.svh"

module program_rom
  import tama_load_pkg::*;
  import tama_mem_pkg::*;
(
  input  logic                        clk_32_768,
  input  decoded_write_t              dec,
  input  logic [`TAMA_ROM_ADDR_W-1:0] rom_addr,
  output logic [`TAMA_ROM_DATA_W-1:0] rom_data
);

  rom_word_t rom_mem [`TAMA_ROM_DEPTH];
  logic      rom_we;
  logic [`TAMA_ROM_ADDR_W-1:0] wr_addr;
  rom_word_t rd_word;

  assign rom_we = dec.valid && (dec.target == target_rom);
  // byte address from host, rom is word addressed
  assign wr_addr = dec.addr[`TAMA_ROM_ADDR_W:1];

  ////////////////////
  // download write port
  always_ff @(posedge clk_32_768) begin
    if (rom_we) begin
      rom_mem[wr_addr] <= dec.data_swapped;
    end
  end

  ////////////////////
  // cpu read port
  assign rd_word = rom_mem[rom_addr];

  always_ff @(posedge clk_32_768) begin
    // 12 bit opcodes, top nibble dropped
    rom_data <= rd_word[`TAMA_ROM_DATA_W-1:0];
  end

  // byte address past the rom would alias onto low words
  a_rom_write_in_range: assert property (
    @(posedge clk_32_768)
    rom_we |-> (dec.addr < (2 * `TAMA_ROM_DEPTH))
  );

endmodule

/* src/clock_enable_gen.sv */
// cpu clock enable generator
// down counter on clk_32_768 giving a 1x tick every count + 1 cycles
// and a 2x tick at the half count and alongside each 1x tick
`timescale 1ns/1ps
`include "tama_defs.svh"

module clock_enable_gen (
  input  logic clk_32_768,
  input  logic rst,
  output logic clk_en,
  output logic clk_2x_en
);

  localparam int CNT_W = $clog2(`TAMA_CLOCK_DIV_COUNT + 1);
  localparam logic [CNT_W-1:0] DIV_RELOAD = CNT_W'(`TAMA_CLOCK_DIV_COUNT);
  localparam logic [CNT_W-1:0] DIV_HALF   = CNT_W'(`TAMA_CLOCK_DIV_COUNT / 2);

  logic [CNT_W-1:0] div_cnt;

  ////////////////////
  // divider
  always_ff @(posedge clk_32_768) begin
    if (rst) begin
      div_cnt   <= DIV_RELOAD;
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
    end else begin
      // single cycle pulses by default
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
      if (div_cnt == '0) begin
        div_cnt   <= DIV_RELOAD;
        clk_en    <= 1'b1;
        clk_2x_en <= 1'b1;
      end else begin
        div_cnt <= div_cnt - 1'b1;
        // midpoint tick for the double rate domain
        if (div_cnt == DIV_HALF) begin
          clk_2x_en <= 1'b1;
        end
      end
    end
  end

  // cpu expects the 2x phase aligned with every 1x tick
  // and the midpoint 2x tick half a period before it
  a_clk_en_has_2x: assert property (
    @(posedge clk_32_768) disable iff (rst)
    clk_en |-> clk_2x_en && $past(clk_2x_en, `TAMA_CLOCK_DIV_COUNT / 2)
  );

endmodule

/* src/tama_core.sv */
// tama core top level
// routes host downloads to the program rom and image write port,
// and generates the cpu clock enables
`timescale 1ns/1ps

module tama_core
  import tama_load_pkg::*;
  import tama_mem_pkg::*;
(
  input  logic         clk_32_768,
  input  logic         rst,
  // host download bus
  input  load_write_t  load,
  // cpu rom port
  input  logic [12:0]  rom_addr,
  output logic [11:0]  rom_data,
  // toward video memories
  output image_write_t image_wr,
  // cpu tick enables
  output logic         clk_en,
  output logic         clk_2x_en
);

  // decoded load write, shared by rom and image paths
  decoded_write_t dec;

  ////////////////////
  // download path
  download_decode u_download_decode (
    .clk_32_768 (clk_32_768),
    .rst        (rst),
    .load       (load),
    .dec        (dec)
  );

  image_write_split u_image_write_split (
    .clk_32_768 (clk_32_768),
    .rst        (rst),
    .dec        (dec),
    .image_wr   (image_wr)
  );

  program_rom u_program_rom (
    .clk_32_768 (clk_32_768),
    .dec        (dec),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data)
  );

  ////////////////////
  // cpu clocking
  clock_enable_gen u_clock_enable_gen (
    .clk_32_768 (clk_32_768),
    .rst        (rst),
    .clk_en     (clk_en),
    .clk_2x_en  (clk_2x_en)
  );

endmodule

/* verif/tb_tama_core.sv */
// tama core testbench
// random download writes from an lfsr, checked against a reference model
// of the rom, the image write port and the cpu clock enables
`timescale 1ns/1ps
`include "tama_defs.svh"

module tb_tama_core
  import tama_load_pkg::*;
  import tama_mem_pkg::*;
();

  typedef struct {
    int           due;
    image_write_t w;
  } exp_write_t;

  logic         clk_32_768;
  logic         rst;
  load_write_t  load;
  logic [12:0]  rom_addr;
  logic [11:0]  rom_data;
  image_write_t image_wr;
  logic         clk_en;
  logic         clk_2x_en;

  logic [15:0]  lfsr = 16'd27;
  logic [15:0]  rom_model [`TAMA_ROM_DEPTH];
  exp_write_t   exp_q [$];
  logic [12:0]  rom_written [$];
  int           cyc = 0;
  int           run_cyc = 0;
  int           error_count = 0;

  tama_core UUT (
    .clk_32_768 (clk_32_768),
    .rst        (rst),
    .load       (load),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .image_wr   (image_wr),
    .clk_en     (clk_en),
    .clk_2x_en  (clk_2x_en)
  );

  initial begin
    clk_32_768 = 1'b0;
    forever #20 clk_32_768 = ~clk_32_768;
  end

  ////////////////////
  // random source
  // galois form, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    rand_bits = r;
  endfunction

  ////////////////////
  // reporting
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t ns: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_run(input string reason);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, reason);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  // cycle counts, total and since reset release
  always @(posedge clk_32_768) begin
    cyc <= cyc + 1;
    if (!rst) begin
      run_cyc <= run_cyc + 1;
    end
  end

  ////////////////////
  // output monitor, sampled mid cycle
  always @(negedge clk_32_768) begin
    // 1x tick every 401 cycles, 2x tick also at phase 201
    check_value("clk_en", clk_en, (run_cyc > 0) && (run_cyc % 401 == 0));
    check_value("clk_2x_en", clk_2x_en,
                (run_cyc > 0) && ((run_cyc % 401 == 0) || (run_cyc % 401 == 201)));
    if (image_wr.background_we || image_wr.spritesheet_we) begin
      if (exp_q.size() == 0) begin
        fail_run("image write appeared with none expected");
      end else begin
        check_value("image write cycle", cyc, exp_q[0].due);
        check_value("background_we", image_wr.background_we, exp_q[0].w.background_we);
        check_value("spritesheet_we", image_wr.spritesheet_we, exp_q[0].w.spritesheet_we);
        check_value("image addr", image_wr.addr, exp_q[0].w.addr);
        check_value("image data", image_wr.data, exp_q[0].w.data);
        void'(exp_q.pop_front());
      end
    end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
      fail_run("expected image write did not appear");
    end
  end

  ////////////////////
  // stimulus helpers
  // one load write, then idle so writes land three cycles apart
  task automatic apply_load(input logic [15:0] slot, input logic [20:0] addr,
                            input logic [15:0] data);
    exp_write_t e;
    @(negedge clk_32_768);
    load = '{wr: 1'b1, addr: addr, data: data, slot_id: slot};
    e.w = '0;
    e.due = cyc + 2;
    if (slot == `TAMA_SLOT_ROM) begin
      rom_model[addr[13:1]] = {data[7:0], data[15:8]};
    end else if (slot == `TAMA_SLOT_BACKGROUND) begin
      e.w = '{background_we: 1'b1, spritesheet_we: 1'b0, addr: addr[17:1],
              data: {data[7:0], data[15:8]}};
      exp_q.push_back(e);
    end else if (slot == `TAMA_SLOT_SPRITESHEET) begin
      // full word at byte address, then high byte at the next one
      e.w = '{background_we: 1'b0, spritesheet_we: 1'b1, addr: addr[16:0], data: data};
      exp_q.push_back(e);
      e.due = cyc + 3;
      e.w.addr = addr[16:0] + 17'd1;
      e.w.data = {8'h00, data[15:8]};
      exp_q.push_back(e);
    end
    @(negedge clk_32_768);
    load = '0;
    @(negedge clk_32_768);
  endtask

  // rom read, data one cycle after the address
  task automatic read_check(input logic [12:0] a);
    @(negedge clk_32_768);
    rom_addr = a;
    @(negedge clk_32_768);
    check_value("rom_data", rom_data, rom_model[a][11:0]);
  endtask

  task automatic wait_image_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < 20) begin
      @(negedge clk_32_768);
      t++;
    end
    if (exp_q.size() != 0) begin
      fail_run("timeout waiting for expected image writes");
    end
  endtask

  ////////////////////
  // test sequence
  initial begin
    logic [20:0] a;
    logic [15:0] s;
    int          t;
    rst = 1'b1;
    load = '0;
    rom_addr = '0;
    repeat (2) @(negedge clk_32_768);
    rst = 1'b0;

    // rom load, byte addresses kept inside the rom
    for (int i = 0; i < 40; i++) begin
      a = rand_bits(14);
      rom_written.push_back(a[13:1]);
      apply_load(`TAMA_SLOT_ROM, a, rand_bits(16));
    end
    foreach (rom_written[i]) begin
      read_check(rom_written[i]);
    end

    // background words
    for (int i = 0; i < 20; i++) begin
      apply_load(`TAMA_SLOT_BACKGROUND, rand_bits(21), rand_bits(16));
    end
    wait_image_drain();

    // spritesheet words, two writes each
    for (int i = 0; i < 20; i++) begin
      apply_load(`TAMA_SLOT_SPRITESHEET, rand_bits(21), rand_bits(16));
    end
    wait_image_drain();

    // unknown slots aimed at rom words already written
    for (int i = 0; i < 20; i++) begin
      s = rand_bits(16);
      if (s == `TAMA_SLOT_ROM || s == `TAMA_SLOT_BACKGROUND || s == `TAMA_SLOT_SPRITESHEET) begin
        s = s + 16'd100;
      end
      a = {7'd0, rom_written[i], 1'b0};
      apply_load(s, a, rand_bits(16));
    end
    wait_image_drain();
    foreach (rom_written[i]) begin
      read_check(rom_written[i]);
    end

    // let the divider run at least five periods
    t = 0;
    while (run_cyc < 5 * 401 + 10 && t < 3000) begin
      @(negedge clk_32_768);
      t++;
    end
    if (run_cyc < 5 * 401 + 10) begin
      fail_run("timeout waiting for clock enable periods");
    end

    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+src
src/tama_load_pkg.sv
src/tama_mem_pkg.sv
src/download_decode.sv
src/image_write_split.sv
src/program_rom.sv
src/clock_enable_gen.sv
src/tama_core.sv
verif/tb_tama_core.sv
